// File: common/uart_consts.svh
// ####################
// Fixed UART frame and sampling sizes
// Include where cycle counts or bit counts are compared
// ####################

`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Data bits in one frame, sent and received LSB first
`define UART_DATA_BITS 8

// BaudTick cycles spent on every bit of the frame
`define UART_OVERSAMPLE 16

// Cycles from the start edge to the middle of the start bit
`define UART_HALF_BIT 8

// One start bit, the data bits and one stop bit
`define UART_FRAME_BITS (`UART_DATA_BITS + 2)

`endif

// File: common/uartPkg.sv
// ####################
// Shared UART types for the transmitter and receiver chain
// Modules pull these in with a wildcard import
// ####################

`include "uart_consts.svh"

package uartPkg;

  // One character on the wire
  typedef logic [`UART_DATA_BITS-1:0] uartByte;

  // Tick position inside one bit period
  typedef logic [$clog2(`UART_OVERSAMPLE)-1:0] sampleCount;

  // Data bit position inside the frame
  typedef logic [$clog2(`UART_DATA_BITS)-1:0] bitIndex;

  // Transmit frame phase
  typedef enum logic [1:0] {
    txIdle,
    txStart,
    txData,
    txStop
  } txState;

  // Receive frame phase
  typedef enum logic [1:0] {
    rxIdle,
    rxStart,
    rxData,
    rxStop
  } rxState;

endpackage

// File: transmitter/txSerializer.sv
// ####################
// UART transmitter, one start bit, eight data bits and one stop bit
// Pulse txLoad with txData while txBusy is low to send a byte
// Every bit lasts 16 BaudTick cycles
// ####################

`timescale 1ns/1ps
`include "uart_consts.svh"

module txSerializer
  import uartPkg::*;
(
  input  logic    BaudTick,
  input  logic    arstN,
  input  logic    txLoad,
  input  uartByte txData,
  output logic    txd,
  output logic    txBusy
);

  txState     state;
  sampleCount tickCount;
  bitIndex    bitCount;
  uartByte    shiftReg;
  logic       accept;
  logic       bitEnd;

  // Loads only count while the line is idle
  assign accept = txLoad && (state == txIdle);

  // Last tick of the current bit period
  assign bitEnd = (tickCount == sampleCount'(`UART_OVERSAMPLE - 1));

  // Busy covers all 160 cycles of the frame
  assign txBusy = (state != txIdle);

  always_ff @(posedge BaudTick or negedge arstN)
  begin
    if (!arstN)
    begin
      state     <= txIdle;
      tickCount <= '0;
      bitCount  <= '0;
      txd       <= 1'b1;
    end
    else
    begin
      case (state)
        txIdle:
        begin
          tickCount <= '0;
          bitCount  <= '0;
          // Start bit goes out right after the accepting edge
          if (accept)
          begin
            state <= txStart;
            txd   <= 1'b0;
          end
        end
        txStart:
        begin
          tickCount <= tickCount + 1'b1;
          if (bitEnd)
          begin
            // Package scope, the txData port hides this state name
            state <= uartPkg::txData;
            txd   <= shiftReg[0];
          end
        end
        uartPkg::txData:
        begin
          tickCount <= tickCount + 1'b1;
          if (bitEnd)
          begin
            if (bitCount == bitIndex'(`UART_DATA_BITS - 1))
            begin
              // All data bits sent, line goes high for the stop bit
              state <= txStop;
              txd   <= 1'b1;
            end
            else
            begin
              bitCount <= bitCount + 1'b1;
              // Next bit sits one above the one leaving now
              txd      <= shiftReg[1];
            end
          end
        end
        txStop:
        begin
          tickCount <= tickCount + 1'b1;
          // Back to idle with txd still high
          if (bitEnd)
            state <= txIdle;
        end
        default:
        begin
          state <= txIdle;
          txd   <= 1'b1;
        end
      endcase
    end
  end

  // Byte latch doubling as the shift register, LSB leaves first
  always_ff @(posedge BaudTick)
  begin
    if (accept)
      shiftReg <= txData;
    else if ((state == uartPkg::txData) && bitEnd)
      shiftReg <= {1'b0, shiftReg[`UART_DATA_BITS-1:1]};
  end

endmodule

// File: receiver/rxSampler.sv
// ####################
// UART receive front end, synchronizes rxd and finds start bits
// Emits nine mid-bit strobes per frame, eight data then stop
// A start bit still high at mid-bit is dropped as a glitch
// ####################

`timescale 1ns/1ps
`include "uart_consts.svh"

module rxSampler
  import uartPkg::*;
(
  input  logic BaudTick,
  input  logic arstN,
  input  logic rxd,
  output logic sampleStrobe,
  output logic sampleBit
);

  logic       rxdMeta;
  logic       rxdSync;
  rxState     state;
  sampleCount tickCount;
  bitIndex    bitCount;
  logic       sampleNow;

  // Two flops against metastability, idle line is high
  always_ff @(posedge BaudTick or negedge arstN)
  begin
    if (!arstN)
    begin
      rxdMeta <= 1'b1;
      rxdSync <= 1'b1;
    end
    else
    begin
      rxdMeta <= rxd;
      rxdSync <= rxdMeta;
    end
  end

  // Mid-bit of a data or stop bit, 16 ticks after the previous one
  assign sampleNow = ((state == rxData) || (state == rxStop)) &&
                     (tickCount == sampleCount'(`UART_OVERSAMPLE - 1));

  always_ff @(posedge BaudTick or negedge arstN)
  begin
    if (!arstN)
    begin
      state     <= rxIdle;
      tickCount <= '0;
      bitCount  <= '0;
    end
    else
    begin
      case (state)
        rxIdle:
        begin
          tickCount <= '0;
          bitCount  <= '0;
          // Low level may be a start bit
          if (!rxdSync)
            state <= rxStart;
        end
        rxStart:
        begin
          if (tickCount == sampleCount'(`UART_HALF_BIT - 1))
          begin
            tickCount <= '0;
            // Confirm at mid start bit
            if (!rxdSync)
              state <= rxData;
            else
              state <= rxIdle;
          end
          else
            tickCount <= tickCount + 1'b1;
        end
        rxData:
        begin
          // Counter wraps to zero on each sample
          tickCount <= tickCount + 1'b1;
          if (sampleNow)
          begin
            if (bitCount == bitIndex'(`UART_DATA_BITS - 1))
              state <= rxStop;
            else
              bitCount <= bitCount + 1'b1;
          end
        end
        rxStop:
        begin
          tickCount <= tickCount + 1'b1;
          // Stop sample taken, wait for the next falling edge
          if (sampleNow)
            state <= rxIdle;
        end
        default:
          state <= rxIdle;
      endcase
    end
  end

  always_ff @(posedge BaudTick or negedge arstN)
  begin
    if (!arstN)
      sampleStrobe <= 1'b0;
    else
      sampleStrobe <= sampleNow;
  end

  // Line level held alongside the strobe
  always_ff @(posedge BaudTick)
  begin
    if (sampleNow)
      sampleBit <= rxdSync;
  end

endmodule

// File: receiver/rxDeserializer.sv
// ####################
// Collects mid-bit samples into a byte, LSB first
// The ninth strobe of a frame is the stop sample and
// pulses byteDone with the finished byte
// ####################

`timescale 1ns/1ps
`include "uart_consts.svh"

module rxDeserializer
  import uartPkg::*;
(
  input  logic    BaudTick,
  input  logic    arstN,
  input  logic    sampleStrobe,
  input  logic    sampleBit,
  output uartByte byteData,
  output logic    byteDone
);

  uartByte    shiftReg;
  logic [3:0] strobeCount;
  logic       stopSample;

  // Eight data strobes seen, this one is the stop bit
  assign stopSample = sampleStrobe && (strobeCount == 4'(`UART_DATA_BITS));

  always_ff @(posedge BaudTick or negedge arstN)
  begin
    if (!arstN)
    begin
      strobeCount <= '0;
      byteDone    <= 1'b0;
    end
    else
    begin
      byteDone <= stopSample;
      if (stopSample)
        strobeCount <= '0;
      else if (sampleStrobe)
        strobeCount <= strobeCount + 1'b1;
    end
  end

  // New bits enter at the top, first bit ends up at bit 0
  always_ff @(posedge BaudTick)
  begin
    if (sampleStrobe && !stopSample)
      shiftReg <= {sampleBit, shiftReg[`UART_DATA_BITS-1:1]};
  end

  // Stop sample does not shift, byte stays stable through byteDone
  assign byteData = shiftReg;

endmodule

// File: receiver/rxHoldBuffer.sv
// ####################
// One-entry receive buffer between the UART and the reader
// Pulse rxRead while rxReady is high to take rxData
// ####################

`timescale 1ns/1ps

module rxHoldBuffer
  import uartPkg::*;
(
  input  logic    BaudTick,
  input  logic    arstN,
  input  logic    rxEnable,
  input  logic    byteDone,
  input  uartByte byteData,
  input  logic    rxRead,
  output uartByte rxData,
  output logic    rxReady,
  output logic    rxOverflow
);

  logic capture;
  logic store;

  // Frames finishing with the enable low are dropped
  assign capture = byteDone && rxEnable;

  // Room when empty or emptied by a read at this same edge
  assign store = capture && (!rxReady || rxRead);

  always_ff @(posedge BaudTick or negedge arstN)
  begin
    if (!arstN)
    begin
      rxReady    <= 1'b0;
      rxOverflow <= 1'b0;
    end
    else
    begin
      if (store)
        rxReady <= 1'b1;
      else if (rxRead)
        rxReady <= 1'b0;
      // Full and unread, old byte wins
      if (capture && rxReady && !rxRead)
        rxOverflow <= 1'b1;
      else if (rxRead)
        rxOverflow <= 1'b0;
    end
  end

  always_ff @(posedge BaudTick)
  begin
    if (store)
      rxData <= byteData;
  end

endmodule

// File: source/uartTop.sv
// ####################
// UART top, transmitter plus sampler, deserializer and hold buffer
// Both serial pins are ports, loop txd to rxd outside for loopback
// ####################

`timescale 1ns/1ps

module uartTop
  import uartPkg::*;
(
  input  logic    BaudTick,
  input  logic    arstN,
  input  logic    txLoad,
  input  uartByte txData,
  output logic    txd,
  output logic    txBusy,
  input  logic    rxd,
  input  logic    rxEnable,
  input  logic    rxRead,
  output uartByte rxData,
  output logic    rxReady,
  output logic    rxOverflow
);

  // Sampler to deserializer
  logic    sampleStrobe;
  logic    sampleBit;

  // Deserializer to hold buffer
  uartByte byteData;
  logic    byteDone;

  txSerializer uTx (
    .BaudTick (BaudTick),
    .arstN    (arstN),
    .txLoad   (txLoad),
    .txData   (txData),
    .txd      (txd),
    .txBusy   (txBusy)
  );

  rxSampler uRxSampler (
    .BaudTick     (BaudTick),
    .arstN        (arstN),
    .rxd          (rxd),
    .sampleStrobe (sampleStrobe),
    .sampleBit    (sampleBit)
  );

  rxDeserializer uRxDeser (
    .BaudTick     (BaudTick),
    .arstN        (arstN),
    .sampleStrobe (sampleStrobe),
    .sampleBit    (sampleBit),
    .byteData     (byteData),
    .byteDone     (byteDone)
  );

  rxHoldBuffer uRxHold (
    .BaudTick   (BaudTick),
    .arstN      (arstN),
    .rxEnable   (rxEnable),
    .byteDone   (byteDone),
    .byteData   (byteData),
    .rxRead     (rxRead),
    .rxData     (rxData),
    .rxReady    (rxReady),
    .rxOverflow (rxOverflow)
  );

endmodule

// File: bench/uartTbTasks.svh
// ####################
// Testbench helpers included inside uartTb
// Value check, load and read drivers, receive model
// All tasks start and end just after a falling edge
// ####################

`ifndef UART_TB_TASKS_SVH
`define UART_TB_TASKS_SVH

// Bytes accepted by the transmitter in send order
uartByte sentQueue[$];

int      mismatchCount = 0;
int      otherErrors   = 0;
int      checkCount    = 0;
int      acceptCount   = 0;

// Expected hold buffer contents
logic    expReady    = 1'b0;
logic    expOverflow = 1'b0;
uartByte expData     = '0;

task automatic checkValue(input logic [31:0] expected, input logic [31:0] actual,
                          input string what);
  begin
    checkCount++;
    if (expected !== actual)
    begin
      mismatchCount++;
      $display("mismatch at %0t ns: %s expected 0x%0h got 0x%0h",
               $time, what, expected, actual);
    end
  end
endtask

// One load pulse that is accepted only while the line is idle
task automatic driveLoad(input uartByte value);
  logic accepted;
  begin
    accepted = !txBusy;
    txLoad   = 1'b1;
    txData   = value;
    if (accepted)
    begin
      sentQueue.push_back(value);
      acceptCount++;
    end
    @(negedge BaudTick);
    txLoad = 1'b0;
    // Busy and start bit both appear at the accepting edge
    if (accepted)
    begin
      checkValue(1, txBusy, "txBusy after an accepted load");
      checkValue(0, txd, "txd start bit");
    end
  end
endtask

task automatic sendByte(input uartByte value);
  begin
    while (txBusy)
      @(negedge BaudTick);
    driveLoad(value);
  end
endtask

// Wait for a byte in the hold buffer, then take it
task automatic readByte();
  begin
    while (!rxReady)
      @(negedge BaudTick);
    rxRead = 1'b1;
    @(negedge BaudTick);
    rxRead = 1'b0;
  end
endtask

// Every queued byte has gone through a frame end
task automatic waitFramesDone();
  begin
    while ((sentQueue.size() != 0) || txBusy)
      @(negedge BaudTick);
    @(negedge BaudTick);
  end
endtask

// Hold buffer rules applied to the inputs seen at the last rising edge
task automatic stepModel();
  uartByte frameByte;
  logic    capture;
  begin
    frameByte = '0;
    capture   = 1'b0;
    if (doneAtEdge)
    begin
      if (sentQueue.size() == 0)
      begin
        otherErrors++;
        $display("Error at %0t ns: the receiver finished a frame that was never sent",
                 $time);
      end
      else
      begin
        frameByte = sentQueue.pop_front();
        capture   = enableAtEdge;
      end
    end
    // Overflow uses the buffer state before this edge
    if (capture && expReady && !readAtEdge)
      expOverflow = 1'b1;
    else if (readAtEdge)
      expOverflow = 1'b0;
    if (capture && (!expReady || readAtEdge))
    begin
      expData  = frameByte;
      expReady = 1'b1;
    end
    else if (readAtEdge)
      expReady = 1'b0;
  end
endtask

`endif

// File: bench/uartTb.sv
// ####################
// Loopback testbench for uartTop
// Random bytes go out on txd and come back on rxd
// Covers loopback, busy loads, overflow, enable and glitches
// ####################

`timescale 1ns/1ps
`include "uart_consts.svh"

module uartTb
  import uartPkg::*;
();

  // Frame time with some room, and the run limit from 40 frames
  localparam int frameCycles = 170;
  localparam int cycleLimit  = 40 * frameCycles + 200;
  // Busy time of one accepted load
  localparam int frameLength = `UART_FRAME_BITS * `UART_OVERSAMPLE;

  logic    BaudTick;
  logic    arstN;
  logic    txLoad;
  uartByte txData;
  logic    txd;
  logic    txBusy;
  logic    rxd;
  logic    rxEnable;
  logic    rxRead;
  uartByte rxData;
  logic    rxReady;
  logic    rxOverflow;
  logic    glitchForce;

  // Inputs seen by the DUT at the last rising edge
  logic    readAtEdge   = 1'b0;
  logic    enableAtEdge = 1'b0;
  logic    doneAtEdge   = 1'b0;
  int      busyCount    = 0;
  int      busyPulses   = 0;
  int      cycleCount   = 0;

  `include "uartTbTasks.svh"

  uartTop UUT (
    .BaudTick   (BaudTick),
    .arstN      (arstN),
    .txLoad     (txLoad),
    .txData     (txData),
    .txd        (txd),
    .txBusy     (txBusy),
    .rxd        (rxd),
    .rxEnable   (rxEnable),
    .rxRead     (rxRead),
    .rxData     (rxData),
    .rxReady    (rxReady),
    .rxOverflow (rxOverflow)
  );

  // Loopback wire with a forced low for glitches
  assign rxd = glitchForce ? 1'b0 : txd;

  initial
    BaudTick = 1'b0;

  always #20 BaudTick = ~BaudTick;

  // Input capture and run limit
  always @(posedge BaudTick)
  begin
    readAtEdge   = rxRead;
    enableAtEdge = rxEnable;
    cycleCount   = cycleCount + 1;
    if (cycleCount >= cycleLimit)
    begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("Simulation failed");
      $finish;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge BaudTick)
  begin
    if (arstN)
    begin
      stepModel();
      checkValue(expReady, rxReady, "rxReady");
      checkValue(expOverflow, rxOverflow, "rxOverflow");
      if (expReady)
        checkValue(expData, rxData, "rxData");
      // Length of each busy period
      if (txBusy)
        busyCount++;
      else if (busyCount != 0)
      begin
        checkValue(frameLength, busyCount, "txBusy cycles per load");
        busyPulses++;
        busyCount = 0;
      end
      doneAtEdge = UUT.byteDone;
    end
  end

  initial
  begin
    uartByte first;
    uartByte second;
    void'($urandom(32'h0b08_8e8b));
    arstN       = 1'b0;
    txLoad      = 1'b0;
    txData      = '0;
    rxEnable    = 1'b1;
    rxRead      = 1'b0;
    glitchForce = 1'b0;
    repeat (4) @(negedge BaudTick);
    arstN = 1'b1;
    @(negedge BaudTick);

    // Idle outputs after reset
    checkValue(1, txd, "txd after reset");
    checkValue(0, txBusy, "txBusy after reset");
    checkValue(0, rxReady, "rxReady after reset");
    checkValue(0, rxOverflow, "rxOverflow after reset");

    // Loopback with extra loads while busy
    fork
      begin
        for (int i = 0; i < 30; i++)
        begin
          repeat ($urandom_range(0, 15)) @(negedge BaudTick);
          sendByte(uartByte'($urandom));
          // Both extras land well inside the 160 busy cycles
          repeat ($urandom_range(0, 2))
          begin
            repeat ($urandom_range(1, 60)) @(negedge BaudTick);
            driveLoad(uartByte'($urandom));
          end
        end
      end
      begin
        for (int j = 0; j < 30; j++)
          readByte();
      end
    join
    waitFramesDone();

    // Two unread frames
    first  = uartByte'($urandom);
    second = uartByte'($urandom);
    sendByte(first);
    sendByte(second);
    waitFramesDone();
    checkValue(1, rxReady, "rxReady after two unread frames");
    checkValue(1, rxOverflow, "rxOverflow after two unread frames");
    checkValue(first, rxData, "rxData keeps the first byte");
    rxRead = 1'b1;
    @(negedge BaudTick);
    rxRead = 1'b0;
    checkValue(0, rxReady, "rxReady after the read");
    checkValue(0, rxOverflow, "rxOverflow after the read");

    // Disabled capture, then a normal frame
    rxEnable = 1'b0;
    sendByte(uartByte'($urandom));
    waitFramesDone();
    checkValue(0, rxReady, "rxReady with capture disabled");
    rxEnable = 1'b1;
    first    = uartByte'($urandom);
    sendByte(first);
    waitFramesDone();
    checkValue(1, rxReady, "rxReady after enable");
    checkValue(first, rxData, "rxData after enable");
    readByte();

    // Short low pulse on an idle line
    glitchForce = 1'b1;
    repeat (4) @(negedge BaudTick);
    glitchForce = 1'b0;
    repeat (frameCycles) @(negedge BaudTick);
    checkValue(0, rxReady, "rxReady after a glitch");
    first = uartByte'($urandom);
    sendByte(first);
    waitFramesDone();
    checkValue(1, rxReady, "rxReady after the glitch frame");
    checkValue(first, rxData, "rxData after the glitch frame");
    readByte();
    @(negedge BaudTick);

    // Totals over the 35 real frames
    checkValue(35, acceptCount, "accepted loads");
    checkValue(acceptCount, busyPulses, "busy periods");
    checkValue(0, sentQueue.size(), "bytes never received");

    $display("Error counts: %0d mismatches, %0d other errors in %0d checks",
             mismatchCount, otherErrors, checkCount);
    if ((mismatchCount == 0) && (otherErrors == 0))
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: uartTop.f
+incdir+common
+incdir+bench
common/uartPkg.sv
transmitter/txSerializer.sv
receiver/rxSampler.sv
receiver/rxDeserializer.sv
receiver/rxHoldBuffer.sv
source/uartTop.sv
bench/uartTb.sv

// File: Bender.yml
package:
  name: uart

sources:
  # Design, the package comes first
  - include_dirs:
      - common
    files:
      - common/uartPkg.sv
      - transmitter/txSerializer.sv
      - receiver/rxSampler.sv
      - receiver/rxDeserializer.sv
      - receiver/rxHoldBuffer.sv
      - source/uartTop.sv

  # Testbench top uartTb
  - target: simulation
    include_dirs:
      - common
      - bench
    files:
      - bench/uartTb.sv
